// File: build.f
+incdir+sim
rtl/fcore_pkg.sv
rtl/constant_bank.sv
rtl/write_merger.sv
rtl/input_sequencer.sv
rtl/fcore_lite.sv
rtl/output_mover.sv
rtl/fcore_complex.sv
sim/tb_fcore_complex.sv

// File: rtl/constant_bank.sv
`timescale 1ns/100ps

module constant_bank (
    input  logic                   core_clock,
    input  logic                   arst_n,
    input  fcore_pkg::cfg_write_t  cfg,
    input  logic                   inject,
    input  logic                   taken,
    output fcore_pkg::reg_write_t  const_write,
    output logic                   pending,
    output logic                   all_loaded
);

    logic [fcore_pkg::data_width-1:0]     value_q [fcore_pkg::n_constants];
    logic [fcore_pkg::reg_addr_width-1:0] target_q [fcore_pkg::n_constants];
    logic [fcore_pkg::n_constants-1:0]    written_q;
    logic [fcore_pkg::n_constants-1:0]    pend_q;
    logic [fcore_pkg::cfg_word_width-1:0] word;
    logic [fcore_pkg::const_idx_width-1:0] cfg_idx;
    logic [fcore_pkg::const_idx_width-1:0] sel;
    logic                                 cfg_hit;

    assign word = cfg.addr[fcore_pkg::cfg_word_width+1:2];
    assign cfg_idx = word[fcore_pkg::const_idx_width:1];
    assign cfg_hit = cfg.strobe && (cfg.addr[15:12] == fcore_pkg::region_const) &&
                     (word < fcore_pkg::cfg_word_width'(2 * fcore_pkg::n_constants));

    // Even words carry the value, odd words the target register
    always_ff @(posedge core_clock) begin
        if (cfg_hit && !word[0]) begin
            value_q[cfg_idx] <= cfg.data;
        end
        if (cfg_hit && word[0]) begin
            target_q[cfg_idx] <= cfg.data[fcore_pkg::reg_addr_width-1:0];
        end
    end

    // Lowest pending constant goes first
    always_comb begin
        sel = '0;
        for (int i = fcore_pkg::n_constants - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                sel = fcore_pkg::const_idx_width'(i);
            end
        end
    end

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            written_q <= '0;
            pend_q <= '0;
        end else begin
            if (cfg_hit && !word[0]) begin
                written_q[cfg_idx] <= 1'b1;
            end
            if (inject) begin
                pend_q <= '1;
            end else if (taken) begin
                pend_q[sel] <= 1'b0;
            end
        end
    end

    assign const_write.strobe = |pend_q;
    assign const_write.addr = target_q[sel];
    assign const_write.data = value_q[sel];
    assign pending = |pend_q;
    assign all_loaded = &written_q;

    a_inject_idle: assert property (@(posedge core_clock) disable iff (!arst_n)
        inject |-> !pending)
        else $error("inject while constants still pending");

endmodule

// File: rtl/fcore_complex.sv
`timescale 1ns/100ps

module fcore_complex (
    input  logic                  core_clock,
    input  logic                  arst_n,
    input  fcore_pkg::cfg_write_t cfg,
    input  fcore_pkg::reg_write_t dma_in,
    input  logic                  start,
    output fcore_pkg::out_word_t  data_out,
    output logic                  done
);

    fcore_pkg::reg_write_t                const_write;
    fcore_pkg::reg_write_t                reg_write;
    logic                                 taken;
    logic                                 merged_active;
    logic                                 pending;
    logic                                 all_loaded;
    logic                                 inject;
    logic                                 run;
    logic                                 core_done;
    logic                                 rd_strobe;
    logic [fcore_pkg::reg_addr_width-1:0] rd_addr;
    logic [fcore_pkg::data_width-1:0]     rd_data;

    constant_bank u_constant_bank (
        .core_clock  (core_clock),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .inject      (inject),
        .taken       (taken),
        .const_write (const_write),
        .pending     (pending),
        .all_loaded  (all_loaded)
    );

    write_merger u_write_merger (
        .dma_in        (dma_in),
        .const_write   (const_write),
        .reg_write     (reg_write),
        .taken         (taken),
        .merged_active (merged_active)
    );

    input_sequencer u_input_sequencer (
        .core_clock    (core_clock),
        .arst_n        (arst_n),
        .start         (start),
        .all_loaded    (all_loaded),
        .pending       (pending),
        .merged_active (merged_active),
        .core_done     (core_done),
        .inject        (inject),
        .run           (run)
    );

    fcore_lite u_fcore_lite (
        .core_clock (core_clock),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .reg_write  (reg_write),
        .run        (run),
        .rd_strobe  (rd_strobe),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .core_done  (core_done)
    );

    output_mover u_output_mover (
        .core_clock (core_clock),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .core_done  (core_done),
        .rd_data    (rd_data),
        .rd_strobe  (rd_strobe),
        .rd_addr    (rd_addr),
        .data_out   (data_out),
        .done       (done)
    );

endmodule

// File: rtl/fcore_lite.sv
`timescale 1ns/100ps

module fcore_lite (
    input  logic                                 core_clock,
    input  logic                                 arst_n,
    input  fcore_pkg::cfg_write_t                cfg,
    input  fcore_pkg::reg_write_t                reg_write,
    input  logic                                 run,
    input  logic                                 rd_strobe,
    input  logic [fcore_pkg::reg_addr_width-1:0] rd_addr,
    output logic [fcore_pkg::data_width-1:0]     rd_data,
    output logic                                 core_done
);

    fcore_pkg::instr_t                     imem [fcore_pkg::prog_depth];
    logic [fcore_pkg::data_width-1:0]      rf [2**fcore_pkg::reg_addr_width];
    logic [fcore_pkg::prog_addr_width-1:0] pc_q;
    logic                                  running_q;
    fcore_pkg::instr_t                     instr;
    logic [fcore_pkg::data_width-1:0]      op_a;
    logic [fcore_pkg::data_width-1:0]      op_b;
    logic [fcore_pkg::data_width-1:0]      alu_result;
    logic                                  alu_we;
    logic                                  exec_we;
    logic                                  run_end;
    logic [fcore_pkg::cfg_word_width-1:0]  word;
    logic                                  prog_hit;

    assign word = cfg.addr[fcore_pkg::cfg_word_width+1:2];
    assign prog_hit = cfg.strobe && (cfg.addr[15:12] == fcore_pkg::region_prog) &&
                      (word < fcore_pkg::cfg_word_width'(fcore_pkg::prog_depth));

    always_ff @(posedge core_clock) begin
        if (prog_hit) begin
            imem[word[fcore_pkg::prog_addr_width-1:0]] <= fcore_pkg::instr_t'(cfg.data);
        end
    end

    assign instr = imem[pc_q];
    assign op_a = rf[instr.src_a];
    assign op_b = rf[instr.src_b];

    always_comb begin
        alu_we = 1'b1;
        alu_result = '0;
        case (instr.opcode)
            fcore_pkg::op_add: alu_result = op_a + op_b;
            fcore_pkg::op_sub: alu_result = op_a - op_b;
            fcore_pkg::op_and: alu_result = op_a & op_b;
            fcore_pkg::op_or:  alu_result = op_a | op_b;
            fcore_pkg::op_xor: alu_result = op_a ^ op_b;
            fcore_pkg::op_shl: alu_result = op_a << op_b[4:0];
            fcore_pkg::op_ldi: alu_result = {{20{instr.imm[11]}}, instr.imm};
            default: alu_we = 1'b0;
        endcase
    end

    assign exec_we = running_q && alu_we;

    // A stop, or falling off the end of the program memory, ends the run
    assign run_end = (instr.opcode == fcore_pkg::op_stop) ||
                     (pc_q == fcore_pkg::prog_addr_width'(fcore_pkg::prog_depth - 1));

    always_ff @(posedge core_clock) begin
        if (exec_we) begin
            rf[instr.dest] <= alu_result;
        end else if (!running_q && reg_write.strobe) begin
            rf[reg_write.addr] <= reg_write.data;
        end
        if (rd_strobe) begin
            rd_data <= rf[rd_addr];
        end
    end

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            running_q <= 1'b0;
            pc_q <= '0;
            core_done <= 1'b0;
        end else begin
            core_done <= 1'b0;
            if (running_q) begin
                pc_q <= pc_q + 1'b1;
                if (run_end) begin
                    running_q <= 1'b0;
                    core_done <= 1'b1;
                end
            end else if (run) begin
                running_q <= 1'b1;
                pc_q <= '0;
            end
        end
    end

    a_no_load_in_run: assert property (@(posedge core_clock) disable iff (!arst_n)
        reg_write.strobe |-> !running_q)
        else $error("register write dropped while the core is running");

endmodule

// File: rtl/fcore_pkg.sv
package fcore_pkg;

    localparam int data_width = 32;
    localparam int reg_addr_width = 4;
    localparam int prog_depth = 64;
    localparam int prog_addr_width = $clog2(prog_depth);
    localparam int n_constants = 3;
    localparam int const_idx_width = $clog2(n_constants);
    localparam int n_channels = 4;
    localparam int chan_idx_width = $clog2(n_channels);
    localparam int tag_width = 8;
    localparam int prop_delay = 2;
    localparam int prop_cnt_width = $clog2(prop_delay + 1);

    // Control addresses are byte addresses, bits 15:12 pick the region
    // and bits 11:2 give the word index inside it
    localparam int cfg_addr_width = 16;
    localparam int cfg_word_width = 10;
    localparam logic [3:0] region_prog = 4'd0;
    localparam logic [3:0] region_const = 4'd1;
    localparam logic [3:0] region_mover = 4'd2;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_shl  = 4'd5,
        op_ldi  = 4'd6,
        op_stop = 4'd7
    } opcode_e;

    typedef enum logic [2:0] {
        wait_constants = 3'd0,
        idle           = 3'd1,
        loading        = 3'd2,
        propagate      = 3'd3,
        running        = 3'd4
    } seq_state_e;

    // Bit 31 down to 0: spare, opcode, dest, src_a, src_b, imm
    typedef struct packed {
        logic [3:0]                spare;
        opcode_e                   opcode;
        logic [reg_addr_width-1:0] dest;
        logic [reg_addr_width-1:0] src_a;
        logic [reg_addr_width-1:0] src_b;
        logic [11:0]               imm;
    } instr_t;

    typedef struct packed {
        logic                      strobe;
        logic [cfg_addr_width-1:0] addr;
        logic [data_width-1:0]     data;
    } cfg_write_t;

    typedef struct packed {
        logic                      strobe;
        logic [reg_addr_width-1:0] addr;
        logic [data_width-1:0]     data;
    } reg_write_t;

    typedef struct packed {
        logic                  strobe;
        logic [tag_width-1:0]  tag;
        logic [data_width-1:0] data;
    } out_word_t;

endpackage

// File: rtl/input_sequencer.sv
`timescale 1ns/100ps

module input_sequencer (
    input  logic core_clock,
    input  logic arst_n,
    input  logic start,
    input  logic all_loaded,
    input  logic pending,
    input  logic merged_active,
    input  logic core_done,
    output logic inject,
    output logic run
);

    fcore_pkg::seq_state_e                state_q;
    logic [fcore_pkg::prop_cnt_width-1:0] prop_cnt_q;

    // Constants are armed in the same cycle that start is accepted
    assign inject = (state_q == fcore_pkg::idle) && start;

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= fcore_pkg::wait_constants;
            prop_cnt_q <= '0;
            run <= 1'b0;
        end else begin
            run <= 1'b0;
            case (state_q)
                fcore_pkg::wait_constants: begin
                    if (all_loaded) begin
                        state_q <= fcore_pkg::idle;
                    end
                end
                fcore_pkg::idle: begin
                    if (start) begin
                        state_q <= fcore_pkg::loading;
                    end
                end
                fcore_pkg::loading: begin
                    if (!pending && !merged_active) begin
                        state_q <= fcore_pkg::propagate;
                        prop_cnt_q <= '0;
                    end
                end
                fcore_pkg::propagate: begin
                    prop_cnt_q <= prop_cnt_q + 1'b1;
                    if (prop_cnt_q == fcore_pkg::prop_cnt_width'(fcore_pkg::prop_delay - 1)) begin
                        run <= 1'b1;
                        state_q <= fcore_pkg::running;
                    end
                end
                fcore_pkg::running: begin
                    if (core_done) begin
                        state_q <= fcore_pkg::idle;
                    end
                end
                default: begin
                    state_q <= fcore_pkg::wait_constants;
                end
            endcase
        end
    end

    a_done_when_running: assert property (@(posedge core_clock) disable iff (!arst_n)
        core_done |-> state_q == fcore_pkg::running)
        else $error("core_done outside of a run");

endmodule

// File: rtl/output_mover.sv
`timescale 1ns/100ps

module output_mover (
    input  logic                                 core_clock,
    input  logic                                 arst_n,
    input  fcore_pkg::cfg_write_t                cfg,
    input  logic                                 core_done,
    input  logic [fcore_pkg::data_width-1:0]     rd_data,
    output logic                                 rd_strobe,
    output logic [fcore_pkg::reg_addr_width-1:0] rd_addr,
    output fcore_pkg::out_word_t                 data_out,
    output logic                                 done
);

    logic [fcore_pkg::reg_addr_width-1:0] src_q [fcore_pkg::n_channels];
    logic [fcore_pkg::tag_width-1:0]      tag_q [fcore_pkg::n_channels];
    logic [fcore_pkg::cfg_word_width-1:0] word;
    logic [fcore_pkg::chan_idx_width-1:0] cfg_idx;
    logic                                 cfg_hit;
    logic [fcore_pkg::chan_idx_width-1:0] ch_q;
    logic                                 reading_q;
    logic                                 last_read;
    logic                                 resp_valid_q;
    logic                                 resp_last_q;
    logic [fcore_pkg::tag_width-1:0]      resp_tag_q;

    assign word = cfg.addr[fcore_pkg::cfg_word_width+1:2];
    assign cfg_idx = word[fcore_pkg::chan_idx_width:1];
    assign cfg_hit = cfg.strobe && (cfg.addr[15:12] == fcore_pkg::region_mover) &&
                     (word < fcore_pkg::cfg_word_width'(2 * fcore_pkg::n_channels));

    always_ff @(posedge core_clock) begin
        if (cfg_hit && !word[0]) begin
            src_q[cfg_idx] <= cfg.data[fcore_pkg::reg_addr_width-1:0];
        end
        if (cfg_hit && word[0]) begin
            tag_q[cfg_idx] <= cfg.data[fcore_pkg::tag_width-1:0];
        end
    end

    assign rd_strobe = reading_q;
    assign rd_addr = src_q[ch_q];
    assign last_read = (ch_q == fcore_pkg::chan_idx_width'(fcore_pkg::n_channels - 1));

    always_ff @(posedge core_clock) begin
        if (reading_q) begin
            resp_tag_q <= tag_q[ch_q];
        end
    end

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            reading_q <= 1'b0;
            ch_q <= '0;
            resp_valid_q <= 1'b0;
            resp_last_q <= 1'b0;
            done <= 1'b0;
        end else begin
            resp_valid_q <= reading_q;
            resp_last_q <= reading_q && last_read;
            done <= resp_valid_q && resp_last_q;
            if (reading_q) begin
                ch_q <= ch_q + 1'b1;
                if (last_read) begin
                    reading_q <= 1'b0;
                end
            end else if (core_done) begin
                reading_q <= 1'b1;
                ch_q <= '0;
            end
        end
    end

    // Read data returns one cycle after the request, in channel order
    assign data_out.strobe = resp_valid_q;
    assign data_out.tag = resp_tag_q;
    assign data_out.data = rd_data;

    a_done_while_moving: assert property (@(posedge core_clock) disable iff (!arst_n)
        core_done |-> !reading_q)
        else $error("core_done dropped while outputs are still being read");

endmodule

// File: rtl/write_merger.sv
`timescale 1ns/100ps

module write_merger (
    input  fcore_pkg::reg_write_t dma_in,
    input  fcore_pkg::reg_write_t const_write,
    output fcore_pkg::reg_write_t reg_write,
    output logic                  taken,
    output logic                  merged_active
);

    // The input stream always wins, a constant simply waits for a free cycle
    always_comb begin
        if (dma_in.strobe) begin
            reg_write = dma_in;
            taken = 1'b0;
        end else begin
            reg_write = const_write;
            taken = const_write.strobe;
        end
    end

    assign merged_active = reg_write.strobe;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the fcore_complex testbench with Verilator, output goes to sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -f build.f \
    --top-module tb_fcore_complex > sim.log 2>&1 || { echo "build failed, see sim.log"; exit 1; }
./obj_dir/Vtb_fcore_complex >> sim.log 2>&1

grep -q "\*\* FAIL \*\*" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "\*\* PASS \*\*" sim.log || { echo "simulation did not complete, see sim.log"; exit 1; }
echo "simulation passed"

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Fibonacci LFSR with taps 16, 14, 13 and 11
logic [15:0] lfsr_state = 16'd12;
logic [31:0] model_prog [fcore_pkg::prog_depth];
logic [31:0] model_rf [16];

function automatic logic lfsr_step();
    logic feedback;
    feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], feedback};
    return feedback;
endfunction

function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], lfsr_step()};
    end
    return value;
endfunction

function automatic logic [31:0] encode_instr(input fcore_pkg::opcode_e op,
                                             input logic [3:0] dest,
                                             input logic [3:0] src_a,
                                             input logic [3:0] src_b,
                                             input logic [11:0] imm);
    fcore_pkg::instr_t ins;
    ins.spare = 4'd0;
    ins.opcode = op;
    ins.dest = dest;
    ins.src_a = src_a;
    ins.src_b = src_b;
    ins.imm = imm;
    return ins;
endfunction

// Runs the program on the model register file, one instruction per step
// until a stop or the last program word
function automatic void execute_model();
    fcore_pkg::instr_t ins;
    logic [31:0]       a;
    logic [31:0]       b;
    for (int pc = 0; pc < fcore_pkg::prog_depth; pc++) begin
        ins = fcore_pkg::instr_t'(model_prog[pc]);
        if (ins.opcode == fcore_pkg::op_stop) begin
            break;
        end
        a = model_rf[ins.src_a];
        b = model_rf[ins.src_b];
        case (ins.opcode)
            fcore_pkg::op_add: model_rf[ins.dest] = a + b;
            fcore_pkg::op_sub: model_rf[ins.dest] = a - b;
            fcore_pkg::op_and: model_rf[ins.dest] = a & b;
            fcore_pkg::op_or:  model_rf[ins.dest] = a | b;
            fcore_pkg::op_xor: model_rf[ins.dest] = a ^ b;
            fcore_pkg::op_shl: model_rf[ins.dest] = a << b[4:0];
            fcore_pkg::op_ldi: model_rf[ins.dest] = {{20{ins.imm[11]}}, ins.imm};
            default: ;
        endcase
    end
endfunction

`endif

// File: sim/tb_fcore_complex.sv
`timescale 1ns/100ps

module tb_fcore_complex;

    localparam int n_runs = 24;
    localparam int cycles_per_run = 200;

    logic                  core_clock;
    logic                  arst_n;
    logic                  start;
    fcore_pkg::cfg_write_t cfg;
    fcore_pkg::reg_write_t dma_in;
    fcore_pkg::out_word_t  data_out;
    logic                  done;

    logic [31:0] const_value [fcore_pkg::n_constants];
    logic [3:0]  const_target [fcore_pkg::n_constants];
    logic [3:0]  chan_src [fcore_pkg::n_channels];
    logic [7:0]  chan_tag [fcore_pkg::n_channels];
    logic [31:0] exp_data [fcore_pkg::n_channels];
    logic [7:0]  got_tag [$];
    logic [31:0] got_data [$];
    int          data_errors = 0;
    int          other_errors = 0;
    int          runs_started = 0;
    int          runs_done = 0;

    `include "tb_model.svh"

    fcore_complex u_fcore_complex (
        .core_clock (core_clock),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .dma_in     (dma_in),
        .start      (start),
        .data_out   (data_out),
        .done       (done)
    );

    always #5 core_clock = ~core_clock;

    task automatic write_cfg(input logic [3:0] region, input int word, input logic [31:0] data);
        cfg.strobe = 1'b1;
        cfg.addr = {region, 10'(word), 2'b00};
        cfg.data = data;
        @(negedge core_clock);
        cfg.strobe = 1'b0;
    endtask

    task automatic write_program(input int len);
        for (int i = 0; i < len; i++) begin
            write_cfg(fcore_pkg::region_prog, i, model_prog[i]);
        end
    endtask

    task automatic set_constant(input int k, input logic [31:0] value, input logic [3:0] target);
        const_value[k] = value;
        const_target[k] = target;
        write_cfg(fcore_pkg::region_const, 2 * k + 1, {28'd0, target});
        write_cfg(fcore_pkg::region_const, 2 * k, value);
    endtask

    task automatic set_channel(input int c, input logic [3:0] src, input logic [7:0] tag);
        chan_src[c] = src;
        chan_tag[c] = tag;
        write_cfg(fcore_pkg::region_mover, 2 * c, {28'd0, src});
        write_cfg(fcore_pkg::region_mover, 2 * c + 1, {24'd0, tag});
    endtask

    task automatic load_fixed_program();
        model_prog[0] = encode_instr(fcore_pkg::op_ldi, 4'd1, 4'd0, 4'd0, 12'h0f3);
        model_prog[1] = encode_instr(fcore_pkg::op_ldi, 4'd2, 4'd0, 4'd0, 12'h805);
        model_prog[2] = encode_instr(fcore_pkg::op_add, 4'd3, 4'd3, 4'd13, 12'h0);
        model_prog[3] = encode_instr(fcore_pkg::op_sub, 4'd4, 4'd1, 4'd14, 12'h0);
        model_prog[4] = encode_instr(fcore_pkg::op_and, 4'd5, 4'd3, 4'd2, 12'h0);
        model_prog[5] = encode_instr(fcore_pkg::op_or, 4'd6, 4'd4, 4'd15, 12'h0);
        model_prog[6] = encode_instr(fcore_pkg::op_xor, 4'd7, 4'd5, 4'd6, 12'h0);
        model_prog[7] = encode_instr(fcore_pkg::op_shl, 4'd8, 4'd7, 4'd1, 12'h0);
        model_prog[8] = encode_instr(fcore_pkg::op_add, 4'd9, 4'd8, 4'd2, 12'h0);
        model_prog[9] = encode_instr(fcore_pkg::op_stop, 4'd0, 4'd0, 4'd0, 12'h0);
        write_program(10);
        set_channel(0, 4'd9, 8'ha1);
        set_channel(1, 4'd7, 8'hb2);
        set_channel(2, 4'd4, 8'hc3);
        set_channel(3, 4'd2, 8'hd4);
    endtask

    function automatic logic is_const_target(input int r);
        for (int k = 0; k < fcore_pkg::n_constants; k++) begin
            if (const_target[k] == 4'(r)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // With dma_first low, start rises together with the first dma_in write and the
    // input stream overlaps the constant replay. With dma_first high every register,
    // constant targets included, is written before start and only the replay restores them
    task automatic do_run(input logic dma_first);
        logic [31:0] dma_data [16];
        for (int r = 0; r < 16; r++) begin
            dma_data[r] = random_bits(32);
            if (dma_first || !is_const_target(r)) begin
                model_rf[r] = dma_data[r];
            end
        end
        for (int k = 0; k < fcore_pkg::n_constants; k++) begin
            model_rf[const_target[k]] = const_value[k];
        end
        execute_model();
        for (int c = 0; c < fcore_pkg::n_channels; c++) begin
            exp_data[c] = model_rf[chan_src[c]];
        end
        runs_started++;
        start = !dma_first;
        for (int r = 0; r < 16; r++) begin
            if (dma_first || !is_const_target(r)) begin
                dma_in.strobe = 1'b1;
                dma_in.addr = 4'(r);
                dma_in.data = dma_data[r];
                @(negedge core_clock);
                start = 1'b0;
            end
        end
        dma_in.strobe = 1'b0;
        if (dma_first) begin
            start = 1'b1;
            @(negedge core_clock);
            start = 1'b0;
        end
        wait (runs_done == runs_started);
        @(negedge core_clock);
    endtask

    task automatic check_words();
        if (got_data.size() != fcore_pkg::n_channels) begin
            other_errors++;
            $display("run %0d delivered %0d output words instead of %0d",
                     runs_done + 1, got_data.size(), fcore_pkg::n_channels);
        end
        for (int c = 0; c < got_data.size() && c < fcore_pkg::n_channels; c++) begin
            if (got_tag[c] !== chan_tag[c]) begin
                data_errors++;
                $display("error: data_out.tag on channel %0d is %h, expected %h",
                         c, got_tag[c], chan_tag[c]);
            end
            if (got_data[c] !== exp_data[c]) begin
                data_errors++;
                $display("error: data_out.data on channel %0d is %h, expected %h",
                         c, got_data[c], exp_data[c]);
            end
        end
        got_tag.delete();
        got_data.delete();
    endtask

    task automatic measure_latency();
        int cycles;
        cycles = 0;
        while (u_fcore_complex.core_done !== 1'b1) begin
            @(negedge core_clock);
        end
        do begin
            @(negedge core_clock);
            cycles++;
        end while (done !== 1'b1);
        if (cycles != fcore_pkg::n_channels + 2) begin
            data_errors++;
            $display("error: core_done to done latency is %h cycles, expected %h",
                     cycles, fcore_pkg::n_channels + 2);
        end
    endtask

    // Outputs settle after the rising edge, so they are collected on the falling one
    initial begin
        forever begin
            @(negedge core_clock);
            if (data_out.strobe === 1'b1) begin
                got_tag.push_back(data_out.tag);
                got_data.push_back(data_out.data);
            end
            if (done === 1'b1) begin
                check_words();
                runs_done++;
            end
        end
    end

    initial begin
        repeat (n_runs * cycles_per_run) @(posedge core_clock);
        $display("timeout: the test did not finish within %0d cycles",
                 n_runs * cycles_per_run);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int                 len;
        fcore_pkg::opcode_e op;
        core_clock = 1'b0;
        arst_n = 1'b0;
        start = 1'b0;
        cfg = '0;
        dma_in = '0;
        repeat (2) @(posedge core_clock);
        @(negedge core_clock);
        arst_n = 1'b1;
        @(negedge core_clock);

        load_fixed_program();
        set_constant(0, 32'h1234_5678, 4'd13);
        set_constant(1, 32'hffff_0f0f, 4'd14);
        write_cfg(fcore_pkg::region_const, 5, 32'd15);

        // The third constant has no value yet, so this start must be dropped
        start = 1'b1;
        @(negedge core_clock);
        start = 1'b0;
        repeat (100) begin
            @(negedge core_clock);
            if (data_out.strobe !== 1'b0 || done !== 1'b0) begin
                other_errors++;
                $display("output activity after a start that came before the constants were set");
            end
        end
        set_constant(2, 32'h8000_0003, 4'd15);
        repeat (2) @(negedge core_clock);

        do_run(1'b1);
        do_run(1'b1);
        set_constant(0, 32'h0000_00ff, 4'd13);
        set_constant(1, 32'h7654_3210, 4'd14);
        do_run(1'b0);

        for (int p = 0; p < 20; p++) begin
            len = random_bits(4) + 1;
            for (int i = 0; i < len; i++) begin
                op = fcore_pkg::opcode_e'(4'(random_bits(3)));
                if (op == fcore_pkg::op_stop) begin
                    op = fcore_pkg::op_ldi;
                end
                model_prog[i] = encode_instr(op, 4'(random_bits(4)), 4'(random_bits(4)),
                                             4'(random_bits(4)), 12'(random_bits(12)));
            end
            model_prog[len] = encode_instr(fcore_pkg::op_stop, 4'd0, 4'd0, 4'd0, 12'h0);
            write_program(len + 1);
            for (int c = 0; c < fcore_pkg::n_channels; c++) begin
                set_channel(c, 4'(random_bits(4)), 8'(random_bits(8)));
            end
            do_run(1'(random_bits(1)));
        end

        load_fixed_program();
        fork
            do_run(1'b0);
            measure_latency();
        join

        if (runs_done != n_runs) begin
            other_errors++;
            $display("only %0d of %0d runs completed", runs_done, n_runs);
        end
        $display("runs: %0d, data errors: %0d, other errors: %0d",
                 runs_done, data_errors, other_errors);
        if (data_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
